// ==== Makefile ====
# Verilator build for the wishbone accelerator subsystem

TB_TOP = wb_accel_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TB_TOP) -f wb_accel_top.f

# pass only if the pass line shows up in the output
run: compile
	./obj_dir/V$(TB_TOP) | tee /dev/stderr | grep -x "PASS: all tests" > /dev/null

clean:
	rm -rf obj_dir

// ==== src/accel_pkg.sv ====
/*
 * accelerator side types
 * operand word seen raw by the bridge and as a pair by the units
 */
`default_nettype none

package accel_pkg;

  // single operand width
  localparam int OPERAND_W = 16;

  typedef logic [OPERAND_W-1:0] operand_t;

  // pair view of one bus word
  // a in the upper half, b in the lower half
  typedef struct packed {
    operand_t a;
    operand_t b;
  } operand_pair_t;

  // one bus word, decoded two ways
  // raw for the bridge, pair for the accelerators
  typedef union packed {
    logic [2*OPERAND_W-1:0] raw;
    operand_pair_t          pair;
  } operand_pair_u;

  // product or gcd, zero extended where narrower
  typedef logic [31:0] result_t;

endpackage

`default_nettype wire

// ==== src/stream_gcd.sv ====
/*
 * subtractive euclid gcd unit
 * one operand pair in, zero-extended gcd out, latency depends on data
 */
`timescale 1ns/1ps
`default_nettype none

module stream_gcd (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     in_val_i,
  output logic                     in_rdy_o,
  input  accel_pkg::operand_pair_u in_data_i,
  output logic                     out_val_o,
  input  logic                     out_rdy_i,
  output accel_pkg::result_t       out_data_o
);
  import accel_pkg::*;

  logic     busy_q;
  logic     done_q;
  operand_t a_q;
  operand_t b_q;
  logic     zero_hit;
  logic     a_ge_b;

  assign in_rdy_o = !busy_q && !done_q;
  assign out_val_o = done_q;

  // finished once either side reaches zero
  assign zero_hit = (a_q == '0) || (b_q == '0);
  assign a_ge_b = (a_q >= b_q);

  // the nonzero side is the answer, 0 for gcd(0,0)
  assign out_data_o = {16'h0000, (b_q == '0) ? a_q : b_q};

  //--------------------------------------------------------------------------
  // control
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      if (in_val_i && in_rdy_o) begin
        busy_q <= 1'b1;
      end else if (busy_q && zero_hit) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end else if (done_q && out_rdy_i) begin
        // result taken, free again
        done_q <= 1'b0;
      end
    end
  end

  //--------------------------------------------------------------------------
  // operands
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (in_val_i && in_rdy_o) begin
      a_q <= in_data_i.pair.a;
      b_q <= in_data_i.pair.b;
    end else if (busy_q && !zero_hit) begin
      // larger minus smaller, equal values go to a
      if (a_ge_b) begin
        a_q <= a_q - b_q;
      end else begin
        b_q <= b_q - a_q;
      end
    end
  end

  // subtraction only ever shrinks the pair
  a_no_rise: assert property (@(posedge clk) disable iff (reset)
    busy_q |=> (!busy_q || ((a_q <= $past(a_q)) && (b_q <= $past(b_q)))));

endmodule

`default_nettype wire

// ==== src/stream_mul.sv ====
/*
 * iterative 16x16 shift-add multiplier
 * one operand pair in, unsigned 32-bit product out, MUL_STEPS cycles
 */
`timescale 1ns/1ps
`default_nettype none

`include "wb_accel_defines.svh"

module stream_mul (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     in_val_i,
  output logic                     in_rdy_o,
  input  accel_pkg::operand_pair_u in_data_i,
  output logic                     out_val_o,
  input  logic                     out_rdy_i,
  output accel_pkg::result_t       out_data_o
);
  import accel_pkg::*;

  localparam int STEP_W = $clog2(`MUL_STEPS + 1);

  logic              busy_q;
  logic              done_q;
  logic [STEP_W-1:0] step_q;
  // shifted multiplicand, full product width
  result_t           mcand_q;
  operand_t          mplier_q;
  result_t           acc_q;

  // one word in flight, accept only when empty
  assign in_rdy_o = !busy_q && !done_q;
  assign out_val_o = done_q;
  assign out_data_o = acc_q;

  // control
  always_ff @(posedge clk) begin
    if (reset) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      step_q <= '0;
    end else begin
      if (in_val_i && in_rdy_o) begin
        busy_q <= 1'b1;
        step_q <= '0;
      end else if (busy_q) begin
        step_q <= step_q + 1'b1;
        // last bit handled this cycle
        if (step_q == STEP_W'(`MUL_STEPS - 1)) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end else if (done_q && out_rdy_i) begin
        done_q <= 1'b0;
      end
    end
  end

  // datapath, lsb first
  always_ff @(posedge clk) begin
    if (in_val_i && in_rdy_o) begin
      mcand_q <= {16'h0000, in_data_i.pair.a};
      mplier_q <= in_data_i.pair.b;
      acc_q <= '0;
    end else if (busy_q) begin
      if (mplier_q[0]) begin
        acc_q <= acc_q + mcand_q;
      end
      mcand_q <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  a_step_bound: assert property (@(posedge clk) disable iff (reset)
    step_q <= STEP_W'(`MUL_STEPS));

endmodule

`default_nettype wire

// ==== src/wb_accel_defines.svh ====
/*
 * accelerator subsystem parameters
 * address map of the wishbone window, slot count and multiplier length
 */
`ifndef WB_ACCEL_DEFINES_SVH
`define WB_ACCEL_DEFINES_SVH

//--------------------------------------------------------------------------
// address map
//--------------------------------------------------------------------------

// base of the wishbone window
`define WB_BASE_ADDR 32'h3000_0000
// offsets from the base
`define WB_LOOP_OFFSET 32'h0000_0000
`define WB_ERR_OFFSET 32'h0000_0004
// slot n sits at WB_SLOT_OFFSET + 4n
`define WB_SLOT_OFFSET 32'h0000_0008

//--------------------------------------------------------------------------
// accelerators
//--------------------------------------------------------------------------

// slot 0 multiplier, slot 1 gcd
`define ACCEL_COUNT 2
// one iteration per multiplier bit
`define MUL_STEPS 16

`endif

// ==== src/wb_accel_top.sv ====
/*
 * accelerator subsystem top
 * wishbone bridge with the multiplier at slot 0 and gcd at slot 1
 */
`timescale 1ns/1ps
`default_nettype none

`include "wb_accel_defines.svh"

module wb_accel_top (
  input  logic        clk,
  input  logic        reset,
  input  logic        wbs_stb_i,
  input  logic        wbs_cyc_i,
  input  logic        wbs_we_i,
  input  logic [3:0]  wbs_sel_i,
  input  logic [31:0] wbs_adr_i,
  input  logic [31:0] wbs_dat_i,
  output logic        wbs_ack_o,
  output logic [31:0] wbs_dat_o
);
  import accel_pkg::*;

  // per slot handshakes
  logic [`ACCEL_COUNT-1:0] in_rdy;
  logic [`ACCEL_COUNT-1:0] in_val;
  logic [`ACCEL_COUNT-1:0] out_val;
  logic [`ACCEL_COUNT-1:0] out_rdy;
  // shared operand word, one result per slot
  operand_pair_u           in_data;
  result_t                 out_data [`ACCEL_COUNT];

  wb_stream_bridge #(
    .N_MODULES(`ACCEL_COUNT)
  ) bridge (
    .clk       (clk),
    .reset     (reset),
    .wbs_stb_i (wbs_stb_i),
    .wbs_cyc_i (wbs_cyc_i),
    .wbs_we_i  (wbs_we_i),
    .wbs_sel_i (wbs_sel_i),
    .wbs_adr_i (wbs_adr_i),
    .wbs_dat_i (wbs_dat_i),
    .wbs_ack_o (wbs_ack_o),
    .wbs_dat_o (wbs_dat_o),
    .in_rdy_i  (in_rdy),
    .in_val_o  (in_val),
    .in_data_o (in_data),
    .out_val_i (out_val),
    .out_rdy_o (out_rdy),
    .out_data_i(out_data)
  );

  // slot 0
  stream_mul u_mul (
    .clk       (clk),
    .reset     (reset),
    .in_val_i  (in_val[0]),
    .in_rdy_o  (in_rdy[0]),
    .in_data_i (in_data),
    .out_val_o (out_val[0]),
    .out_rdy_i (out_rdy[0]),
    .out_data_o(out_data[0])
  );

  // slot 1
  stream_gcd u_gcd (
    .clk       (clk),
    .reset     (reset),
    .in_val_i  (in_val[1]),
    .in_rdy_o  (in_rdy[1]),
    .in_data_i (in_data),
    .out_val_o (out_val[1]),
    .out_rdy_i (out_rdy[1]),
    .out_data_o(out_data[1])
  );

endmodule

`default_nettype wire

// ==== src/wb_pkg.sv ====
/*
 * wishbone side types
 * decoded access kinds and the error register codes
 */
`default_nettype none

package wb_pkg;

  // plain bus word, loopback and data paths
  typedef logic [31:0] wb_word_t;

  // decoded kind of one active access
  // only meaningful while stb and cyc are high
  typedef enum logic [2:0] {
    loop_rd     = 3'd0,
    loop_wr     = 3'd1,
    err_rd      = 3'd2,
    mod_rd      = 3'd3,
    // slot still computing, bus held
    mod_rd_wait = 3'd4,
    mod_wr      = 3'd5,
    bad         = 3'd6
  } wb_access_e;

  // error register contents, full bus width
  typedef enum logic [31:0] {
    ERR_NONE      = 32'd0,
    // write to a slot that is not ready
    ERR_MOD_BUSY  = 32'd1,
    // read from an idle slot with no result
    ERR_MOD_EMPTY = 32'd2,
    // outside the window or misaligned
    ERR_ADDR      = 32'd3
  } wb_err_e;

endpackage

`default_nettype wire

// ==== src/wb_stream_bridge.sv ====
/*
 * wishbone slave to valid/ready bridge
 * decodes the window, keeps loopback/error/index regs, waits on busy reads
 */
`timescale 1ns/1ps
`default_nettype none

`include "wb_accel_defines.svh"

module wb_stream_bridge #(
  parameter int N_MODULES = `ACCEL_COUNT
) (
  input  logic                     clk,
  input  logic                     reset,
  // wishbone slave
  input  logic                     wbs_stb_i,
  input  logic                     wbs_cyc_i,
  input  logic                     wbs_we_i,
  // byte selects not supported, full words only
  input  logic [3:0]               wbs_sel_i,
  input  logic [31:0]              wbs_adr_i,
  input  logic [31:0]              wbs_dat_i,
  output logic                     wbs_ack_o,
  output logic [31:0]              wbs_dat_o,
  // accelerator slots
  input  logic [N_MODULES-1:0]     in_rdy_i,
  output logic [N_MODULES-1:0]     in_val_o,
  output accel_pkg::operand_pair_u in_data_o,
  input  logic [N_MODULES-1:0]     out_val_i,
  output logic [N_MODULES-1:0]     out_rdy_o,
  input  accel_pkg::result_t       out_data_i [N_MODULES]
);
  import wb_pkg::*;
  import accel_pkg::*;

  localparam int IDX_W = (N_MODULES > 1) ? $clog2(N_MODULES) : 1;
  // first offset past the last slot
  localparam logic [31:0] SLOT_END = `WB_SLOT_OFFSET + 32'(4 * N_MODULES);

  typedef enum logic {IDLE, BUSY} state_e;

  state_e               state_q;
  state_e               state_d;
  wb_word_t             loopback_q;
  logic                 loop_en;
  wb_err_e              err_q;
  wb_err_e              err_d;
  logic                 err_en;
  logic [IDX_W-1:0]     index_q;
  logic                 index_en;
  logic                 active;
  logic [31:0]          offset;
  logic [31:0]          slot_off;
  logic [IDX_W-1:0]     idx;
  logic                 slot_hit;
  logic [N_MODULES-1:0] idx_onehot;
  logic [N_MODULES-1:0] index_onehot;
  wb_access_e           access;
  result_t              rd_word;

  //--------------------------------------------------------------------------
  // address decode
  //--------------------------------------------------------------------------

  assign active = wbs_stb_i && wbs_cyc_i;
  // below the base wraps high, misses every range
  assign offset = wbs_adr_i - `WB_BASE_ADDR;
  assign slot_off = (offset - `WB_SLOT_OFFSET) >> 2;
  assign idx = slot_off[IDX_W-1:0];
  assign slot_hit = (offset >= `WB_SLOT_OFFSET) && (offset < SLOT_END) &&
                    (offset[1:0] == 2'b00);

  // strobe masks for the addressed and the waiting slot
  assign idx_onehot = N_MODULES'(1) << idx;
  assign index_onehot = N_MODULES'(1) << index_q;

  // all slots see the bus word, in_val picks the taker
  assign in_data_o.raw = wbs_dat_i;

  always_comb begin
    if (offset == `WB_LOOP_OFFSET) begin
      access = wbs_we_i ? loop_wr : loop_rd;
    end else if (offset == `WB_ERR_OFFSET && !wbs_we_i) begin
      access = err_rd;
    end else if (slot_hit) begin
      if (wbs_we_i) begin
        access = mod_wr;
      end else if (!out_val_i[idx] && !in_rdy_i[idx]) begin
        // accepted a word, result not out yet
        access = mod_rd_wait;
      end else begin
        access = mod_rd;
      end
    end else begin
      // includes writes to the error register
      access = bad;
    end
  end

  //--------------------------------------------------------------------------
  // control FSM, strobes, ack and read mux
  //--------------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    in_val_o = '0;
    out_rdy_o = '0;
    wbs_ack_o = 1'b0;
    loop_en = 1'b0;
    err_en = 1'b0;
    err_d = ERR_NONE;
    index_en = 1'b0;
    rd_word = '0;
    case (state_q)
      IDLE: begin
        if (active) begin
          case (access)
            loop_rd: begin
              wbs_ack_o = 1'b1;
              err_en = 1'b1;
              rd_word = loopback_q;
            end
            loop_wr: begin
              wbs_ack_o = 1'b1;
              err_en = 1'b1;
              loop_en = 1'b1;
            end
            // error read leaves the register alone
            err_rd: begin
              wbs_ack_o = 1'b1;
              rd_word = err_q;
            end
            mod_rd: begin
              wbs_ack_o = 1'b1;
              err_en = 1'b1;
              if (out_val_i[idx]) begin
                out_rdy_o = idx_onehot;
                rd_word = out_data_i[idx];
              end else begin
                err_d = ERR_MOD_EMPTY;
              end
            end
            mod_rd_wait: begin
              // no ack, remember the slot and hold the bus
              err_en = 1'b1;
              index_en = 1'b1;
              state_d = BUSY;
            end
            mod_wr: begin
              wbs_ack_o = 1'b1;
              err_en = 1'b1;
              if (in_rdy_i[idx]) begin
                in_val_o = idx_onehot;
              end else begin
                err_d = ERR_MOD_BUSY;
              end
            end
            default: begin
              wbs_ack_o = 1'b1;
              err_en = 1'b1;
              err_d = ERR_ADDR;
            end
          endcase
        end
      end
      BUSY: begin
        // take the result the cycle it shows up
        if (active && out_val_i[index_q]) begin
          wbs_ack_o = 1'b1;
          out_rdy_o = index_onehot;
          rd_word = out_data_i[index_q];
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  assign wbs_dat_o = rd_word;

  // state and registers
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= IDLE;
      loopback_q <= '0;
      err_q <= ERR_NONE;
      index_q <= '0;
    end else begin
      state_q <= state_d;
      if (loop_en) begin
        loopback_q <= wbs_dat_i;
      end
      if (err_en) begin
        err_q <= err_d;
      end
      if (index_en) begin
        index_q <= idx;
      end
    end
  end

  //--------------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------------

  // ack only answers a live request
  a_ack_has_req: assert property (@(posedge clk) disable iff (reset)
    wbs_ack_o |-> (wbs_stb_i && wbs_cyc_i));

  // at most one slot strobed per cycle
  a_strobe_onehot: assert property (@(posedge clk) disable iff (reset)
    $onehot0(in_val_o) && $onehot0(out_rdy_o));

  // never push into a slot that cannot take it
  a_val_needs_rdy: assert property (@(posedge clk) disable iff (reset)
    (in_val_o & ~in_rdy_i) == '0);

endmodule

`default_nettype wire

// ==== testbench/wb_accel_tb.sv ====
/*
 * testbench for the wishbone accelerator subsystem
 * loopback, multiplier, gcd, empty read, busy write and bad address
 */
`timescale 1ns/1ps
`default_nettype none

`include "wb_accel_defines.svh"

module wb_accel_tb;
  import wb_pkg::*;
  import accel_pkg::*;

  // gcd gaps and stalls dominate, 8-bit operands keep each access short
  localparam int CYCLE_LIMIT = 20000;
  localparam int ACK_LIMIT = 100;
  // longest 8-bit subtractive run is 255 steps
  localparam int GCD_GAP = 260;

  logic        clk = 1'b0;
  logic        reset;
  logic        wbs_stb_i;
  logic        wbs_cyc_i;
  logic        wbs_we_i;
  logic [3:0]  wbs_sel_i;
  logic [31:0] wbs_adr_i;
  logic [31:0] wbs_dat_i;
  logic        wbs_ack_o;
  logic [31:0] wbs_dat_o;

  integer seed = 32'h518b;
  int     cycles = 0;
  int     word_errs = 0;
  int     err_errs = 0;
  int     bus_errs = 0;
  // cycles the last access waited for ack
  int     last_wait;

  // expected and observed results, drained by the compare process
  result_t    exp_words [$];
  result_t    got_words [$];
  wb_access_e word_kinds [$];
  wb_err_e    exp_errs [$];
  wb_err_e    got_errs [$];

  wb_accel_top dut (
    .clk      (clk),
    .reset    (reset),
    .wbs_stb_i(wbs_stb_i),
    .wbs_cyc_i(wbs_cyc_i),
    .wbs_we_i (wbs_we_i),
    .wbs_sel_i(wbs_sel_i),
    .wbs_adr_i(wbs_adr_i),
    .wbs_dat_i(wbs_dat_i),
    .wbs_ack_o(wbs_ack_o),
    .wbs_dat_o(wbs_dat_o)
  );

  always #5 clk = ~clk;

  // ------------------------------------------------------------------------
  // reference model and compare
  // ------------------------------------------------------------------------

  // slot 0 product by repeated addition, slot 1 gcd by remainders
  function automatic result_t ref_result(input int slot, input operand_pair_u op);
    result_t     acc;
    logic [15:0] x;
    logic [15:0] y;
    logic [15:0] t;
    acc = '0;
    x = op.pair.a;
    y = op.pair.b;
    if (slot == 0) begin
      for (int i = 0; i < int'(y); i++) begin
        acc = acc + {16'h0000, x};
      end
    end else begin
      while (y != 16'h0000) begin
        t = x % y;
        x = y;
        y = t;
      end
      acc = {16'h0000, x};
    end
    return acc;
  endfunction

  task automatic check_word(input wb_access_e kind, input result_t exp, input result_t act);
    if (exp !== act) begin
      $display("ERR %0t ns: %s word expected %h got %h", $time, kind.name(), exp, act);
      word_errs++;
    end
  endtask

  task automatic check_err(input wb_err_e exp, input wb_err_e act);
    if (exp !== act) begin
      $display("ERR %0t ns: error register expected %s got %s (%h)",
               $time, exp.name(), act.name(), act);
      err_errs++;
    end
  endtask

  // results are pushed between edges, compared at the next rising edge
  always @(posedge clk) begin
    while (got_words.size() > 0) begin
      check_word(word_kinds.pop_front(), exp_words.pop_front(), got_words.pop_front());
    end
    while (got_errs.size() > 0) begin
      check_err(exp_errs.pop_front(), got_errs.pop_front());
    end
  end

  // watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // ------------------------------------------------------------------------
  // bus tasks
  // ------------------------------------------------------------------------

  // one classic cycle, ack sampled mid cycle where it is stable
  task automatic bus_cycle(input logic we, input logic [31:0] adr,
                           input logic [31:0] dat, output logic [31:0] rdata);
    int waited;
    waited = 0;
    rdata = '0;
    @(negedge clk);
    wbs_stb_i = 1'b1;
    wbs_cyc_i = 1'b1;
    wbs_we_i = we;
    wbs_adr_i = adr;
    wbs_dat_i = dat;
    #1;
    while (!wbs_ack_o && waited < ACK_LIMIT) begin
      @(negedge clk);
      #1;
      waited++;
    end
    if (wbs_ack_o) begin
      rdata = wbs_dat_o;
    end else begin
      $display("no ack from bus at %0t ns, address %h", $time, adr);
      bus_errs++;
    end
    last_wait = waited;
    // transfer completes on the next rising edge
    @(negedge clk);
    wbs_stb_i = 1'b0;
    wbs_cyc_i = 1'b0;
    wbs_we_i = 1'b0;
  endtask

  task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat);
    logic [31:0] unused_rd;
    bus_cycle(1'b1, adr, dat, unused_rd);
  endtask

  task automatic wb_read(input logic [31:0] adr, output logic [31:0] data);
    bus_cycle(1'b0, adr, 32'h0, data);
  endtask

  task automatic expect_word(input logic [31:0] adr, input wb_access_e kind,
                             input result_t exp);
    logic [31:0] data;
    wb_read(adr, data);
    word_kinds.push_back(kind);
    exp_words.push_back(exp);
    got_words.push_back(data);
  endtask

  task automatic expect_err(input wb_err_e exp);
    logic [31:0] data;
    wb_read(`WB_BASE_ADDR + `WB_ERR_OFFSET, data);
    exp_errs.push_back(exp);
    got_errs.push_back(wb_err_e'(data));
  endtask

  function automatic logic [31:0] slot_addr(input int slot);
    return `WB_BASE_ADDR + `WB_SLOT_OFFSET + 32'(4 * slot);
  endfunction

  // 8-bit operands bound the gcd run time
  function automatic operand_pair_u rand_pair();
    operand_pair_u op;
    op.pair.a = 16'($random(seed)) & 16'h00ff;
    op.pair.b = 16'($random(seed)) & 16'h00ff;
    return op;
  endfunction

  // ------------------------------------------------------------------------
  // tests
  // ------------------------------------------------------------------------

  initial begin
    operand_pair_u op;
    operand_pair_u op2;
    logic [31:0]   w;
    logic [31:0]   data;
    reset = 1'b1;
    wbs_stb_i = 1'b0;
    wbs_cyc_i = 1'b0;
    wbs_we_i = 1'b0;
    wbs_sel_i = 4'hf;
    wbs_adr_i = '0;
    wbs_dat_i = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // loopback
    for (int i = 0; i < 8; i++) begin
      w = $random(seed);
      wb_write(`WB_BASE_ADDR, w);
      expect_word(`WB_BASE_ADDR, loop_rd, w);
    end
    expect_err(ERR_NONE);

    // multiplier, read right after the write so it stalls
    for (int i = 0; i < 8; i++) begin
      op = rand_pair();
      wb_write(slot_addr(0), op.raw);
      expect_word(slot_addr(0), mod_rd_wait, ref_result(0, op));
      if (last_wait == 0) begin
        $display("multiplier read at %0t ns was acked without waiting", $time);
        bus_errs++;
      end
    end
    expect_err(ERR_NONE);

    // gcd, zero operands on two of the pairs
    for (int i = 0; i < 8; i++) begin
      op = rand_pair();
      if (i == 3) begin
        op.pair.b = 16'h0000;
      end
      if (i == 6) begin
        op.pair.a = 16'h0000;
      end
      wb_write(slot_addr(1), op.raw);
      repeat (GCD_GAP) @(negedge clk);
      expect_word(slot_addr(1), mod_rd, ref_result(1, op));
    end
    expect_err(ERR_NONE);

    // empty read, then cleared by a loopback write
    wb_read(slot_addr(1), data);
    expect_err(ERR_MOD_EMPTY);
    wb_write(`WB_BASE_ADDR, 32'h0);
    expect_err(ERR_NONE);

    // busy write, second word dropped
    op = rand_pair();
    op2 = rand_pair();
    wb_write(slot_addr(0), op.raw);
    wb_write(slot_addr(0), op2.raw);
    expect_err(ERR_MOD_BUSY);
    expect_word(slot_addr(0), mod_rd_wait, ref_result(0, op));

    // past the last slot, then misaligned
    wb_read(`WB_BASE_ADDR + 32'h10, data);
    expect_err(ERR_ADDR);
    wb_write(`WB_BASE_ADDR, 32'h0);
    wb_write(`WB_BASE_ADDR + 32'h2, 32'h1234_5678);
    expect_err(ERR_ADDR);

    // let the compare process drain
    @(posedge clk);
    @(negedge clk);
    $display("errors: word %0d, error register %0d, bus %0d", word_errs, err_errs, bus_errs);
    if (word_errs + err_errs + bus_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== wb_accel_top.f ====
+incdir+src
src/wb_pkg.sv
src/accel_pkg.sv
src/wb_stream_bridge.sv
src/stream_mul.sv
src/stream_gcd.sv
src/wb_accel_top.sv
testbench/wb_accel_tb.sv
